/* common/div_pkg.sv */
// assumes a 32-bit data path, word-aligned APB registers and a power-of-two lane count.
package div_pkg;

  // ----------------------------------------
  // widths and sizes
  // ----------------------------------------
  localparam int data_w = 32;
  localparam int num_lanes = 4;
  localparam int lane_idx_w = 2;
  localparam int result_depth = 4;
  localparam int q_idx_w = 2;
  // queue count, wide enough to hold result_depth.
  localparam int count_w = 3;
  localparam int iter_cnt_w = 5;
  localparam int addr_w = 8;

  // ----------------------------------------
  // register map
  // ----------------------------------------
  localparam logic [addr_w-1:0] reg_dividend = 8'h00;
  localparam logic [addr_w-1:0] reg_divisor = 8'h04;
  // bit 0 selects signed, write issues a job.
  localparam logic [addr_w-1:0] reg_cmd = 8'h08;
  // valid, head div-by-zero, count in bits 4:2.
  localparam logic [addr_w-1:0] reg_status = 8'h0C;
  localparam logic [addr_w-1:0] reg_quotient = 8'h10;
  // read pops the head result.
  localparam logic [addr_w-1:0] reg_remainder = 8'h14;

  // one operand word, read as unsigned or as two's complement.
  typedef union packed {
    logic [data_w-1:0]        u;
    logic signed [data_w-1:0] s;
  } div_word_u;

endpackage

/* common/div_lane_if.sv */
// start is a single-cycle pulse and is legal only while idle; done holds until take.
`timescale 1ns/1ps

interface div_lane_if import div_pkg::*; ();

  logic              start;
  logic              is_signed;
  logic [data_w-1:0] dividend;
  logic [data_w-1:0] divisor;
  logic              idle;
  logic              done;
  logic [data_w-1:0] quotient;
  logic [data_w-1:0] remainder;
  logic              div_by_zero;
  logic              take;

  modport dispatch (
    output start, is_signed, dividend, divisor,
    input  idle
  );

  modport lane (
    input  start, is_signed, dividend, divisor, take,
    output idle, done, quotient, remainder, div_by_zero
  );

  modport collect (
    input  done, quotient, remainder, div_by_zero,
    output take
  );

endinterface

/* rtl/apb_div_regs.sv */
// zero-wait-state APB slave; pready is tied high and a rejected command is reported on pslverr.
`timescale 1ns/1ps

module apb_div_regs import div_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [addr_w-1:0]  paddr,
  input  logic [data_w-1:0]  pwdata,
  output logic [data_w-1:0]  prdata,
  output logic               pready,
  output logic               pslverr,
  output logic               cmd_req,
  output logic               cmd_signed,
  input  logic               cmd_accept,
  output logic [data_w-1:0]  dividend,
  output logic [data_w-1:0]  divisor,
  input  logic               result_valid,
  input  logic [data_w-1:0]  head_quotient,
  input  logic [data_w-1:0]  head_remainder,
  input  logic               head_div_by_zero,
  input  logic [count_w-1:0] result_count,
  output logic               pop
);

  logic wr_en;
  logic rd_en;
  logic [data_w-1:0] status_word;

  // access phase only.
  assign wr_en = psel && penable && pwrite;
  assign rd_en = psel && penable && !pwrite;

  assign pready = 1'b1;

  // ----------------------------------------
  // command and pop strobes
  // ----------------------------------------
  assign cmd_req = wr_en && (paddr == reg_cmd);
  assign cmd_signed = pwdata[0];
  assign pslverr = cmd_req && !cmd_accept;

  // popping an empty queue is ignored.
  assign pop = rd_en && (paddr == reg_remainder) && result_valid;

  // ----------------------------------------
  // operand registers
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dividend <= '0;
      divisor <= '0;
    end else if (wr_en) begin
      if (paddr == reg_dividend) begin
        dividend <= pwdata;
      end
      if (paddr == reg_divisor) begin
        divisor <= pwdata;
      end
    end
  end

  // ----------------------------------------
  // read-back mux
  // ----------------------------------------
  assign status_word = {
    {(data_w - count_w - 2){1'b0}},
    result_count,
    head_div_by_zero && result_valid,
    result_valid
  };

  always_comb begin
    prdata = '0;
    if (rd_en) begin
      case (paddr)
        reg_dividend:  prdata = dividend;
        reg_divisor:   prdata = divisor;
        reg_status:    prdata = status_word;
        // result words read as zero while the queue is empty.
        reg_quotient:  prdata = result_valid ? head_quotient : '0;
        reg_remainder: prdata = result_valid ? head_remainder : '0;
        default:       prdata = '0;
      endcase
    end
  end

endmodule

/* div_array/div_dispatch.sv */
// strict round-robin; a command is rejected when the next lane in turn is busy.
`timescale 1ns/1ps

module div_dispatch import div_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cmd_req,
  input  logic              cmd_signed,
  input  logic [data_w-1:0] dividend,
  input  logic [data_w-1:0] divisor,
  output logic              cmd_accept,
  div_lane_if.dispatch      lanes [num_lanes]
);

  logic [lane_idx_w-1:0] next_lane;
  logic [num_lanes-1:0]  idle_vec;
  logic [num_lanes-1:0]  start_q;
  logic                  signed_q;
  logic [data_w-1:0]     dividend_q;
  logic [data_w-1:0]     divisor_q;

  assign cmd_accept = cmd_req && idle_vec[next_lane];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      next_lane <= '0;
      start_q <= '0;
    end else begin
      start_q <= cmd_accept ? (num_lanes'(1) << next_lane) : '0;
      if (cmd_accept) begin
        next_lane <= next_lane + 1'b1;
      end
    end
  end

  // operands are shared by all lanes, only the started one captures.
  always_ff @(posedge clk) begin
    if (cmd_accept) begin
      signed_q <= cmd_signed;
      dividend_q <= dividend;
      divisor_q <= divisor;
    end
  end

  for (genvar i = 0; i < num_lanes; i++) begin : g_lane_io
    assign idle_vec[i] = lanes[i].idle;
    assign lanes[i].start = start_q[i];
    assign lanes[i].is_signed = signed_q;
    assign lanes[i].dividend = dividend_q;
    assign lanes[i].divisor = divisor_q;
  end

  a_one_start: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(start_q));

endmodule

/* div_array/div_lane.sv */
// fixed latency of data_w + 1 cycles from start to done, also for a zero divisor.
`timescale 1ns/1ps

module div_lane import div_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  div_lane_if.lane lane
);

  div_word_u         a_word;
  div_word_u         b_word;
  logic              a_neg;
  logic              b_neg;
  logic [data_w-1:0] a_mag;
  logic [data_w-1:0] b_mag;

  logic                  busy;
  logic                  done_q;
  logic [iter_cnt_w-1:0] cnt;
  logic                  last_step;

  logic [data_w-1:0] quo;
  logic [data_w-1:0] acc;
  logic [data_w-1:0] div_mag;
  logic              q_neg;
  logic              r_neg;
  logic              zero_div;
  logic [data_w-1:0] quotient_q;
  logic [data_w-1:0] remainder_q;

  logic [data_w:0]   rem_shift;
  logic [data_w-1:0] quo_next;
  logic [data_w-1:0] acc_next;

  // ----------------------------------------
  // operand decode
  // ----------------------------------------
  assign a_word = lane.dividend;
  assign b_word = lane.divisor;

  // sign from the signed view, only for signed jobs.
  assign a_neg = lane.is_signed && (a_word.s < 0);
  assign b_neg = lane.is_signed && (b_word.s < 0);
  // the most negative value maps to its own unsigned magnitude.
  assign a_mag = a_neg ? -a_word.s : a_word.u;
  assign b_mag = b_neg ? -b_word.s : b_word.u;

  // ----------------------------------------
  // restoring step
  // ----------------------------------------
  assign rem_shift = {acc, quo[data_w-1]};

  always_comb begin
    if (rem_shift >= {1'b0, div_mag}) begin
      acc_next = rem_shift[data_w-1:0] - div_mag;
      quo_next = {quo[data_w-2:0], 1'b1};
    end else begin
      acc_next = rem_shift[data_w-1:0];
      quo_next = {quo[data_w-2:0], 1'b0};
    end
  end

  assign last_step = busy && (cnt == iter_cnt_w'(data_w - 1));

  // ----------------------------------------
  // control
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= 1'b0;
      done_q <= 1'b0;
      cnt <= '0;
    end else if (lane.start) begin
      busy <= 1'b1;
      cnt <= '0;
    end else if (busy) begin
      cnt <= cnt + 1'b1;
      if (last_step) begin
        busy <= 1'b0;
        done_q <= 1'b1;
      end
    end else if (lane.take) begin
      done_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (lane.start) begin
      quo <= a_mag;
      acc <= '0;
      div_mag <= b_mag;
      q_neg <= a_neg ^ b_neg;
      r_neg <= a_neg;
      zero_div <= (b_word.u == '0);
    end else if (busy) begin
      quo <= quo_next;
      acc <= acc_next;
      if (last_step) begin
        quotient_q <= zero_div ? '1 : (q_neg ? -quo_next : quo_next);
        // with a zero divisor this gives back the raw dividend.
        remainder_q <= r_neg ? -acc_next : acc_next;
      end
    end
  end

  assign lane.idle = !busy && !done_q;
  assign lane.done = done_q;
  assign lane.quotient = quotient_q;
  assign lane.remainder = remainder_q;
  assign lane.div_by_zero = zero_div;

  a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
    lane.start |-> !busy && !done_q);

endmodule

/* div_array/div_collect.sv */
// results leave in issue order; a slow head lane blocks later finished lanes.
`timescale 1ns/1ps

module div_collect import div_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               pop,
  output logic               result_valid,
  output logic [data_w-1:0]  head_quotient,
  output logic [data_w-1:0]  head_remainder,
  output logic               head_div_by_zero,
  output logic [count_w-1:0] result_count,
  div_lane_if.collect        lanes [num_lanes]
);

  logic [lane_idx_w-1:0] drain_ptr;
  logic [num_lanes-1:0]  done_vec;
  logic [num_lanes-1:0]  dbz_vec;
  logic [data_w-1:0]     quo_vec [num_lanes];
  logic [data_w-1:0]     rem_vec [num_lanes];
  logic [num_lanes-1:0]  take_q;
  logic                  push;
  logic                  full;

  logic [data_w-1:0]  quo_mem [result_depth];
  logic [data_w-1:0]  rem_mem [result_depth];
  logic               dbz_mem [result_depth];
  logic [q_idx_w-1:0] wr_ptr;
  logic [q_idx_w-1:0] rd_ptr;
  logic [count_w-1:0] count;

  for (genvar i = 0; i < num_lanes; i++) begin : g_lane_io
    assign done_vec[i] = lanes[i].done;
    assign dbz_vec[i] = lanes[i].div_by_zero;
    assign quo_vec[i] = lanes[i].quotient;
    assign rem_vec[i] = lanes[i].remainder;
    assign lanes[i].take = take_q[i];
  end

  // entry is written during the take cycle.
  assign push = |take_q;
  assign full = (count == count_w'(result_depth));

  // ----------------------------------------
  // drain and queue control
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      take_q <= '0;
      drain_ptr <= '0;
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      // no second take while the previous one is in flight.
      if (done_vec[drain_ptr] && !full && !push) begin
        take_q <= num_lanes'(1) << drain_ptr;
      end else begin
        take_q <= '0;
      end
      if (push) begin
        drain_ptr <= drain_ptr + 1'b1;
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      quo_mem[wr_ptr] <= quo_vec[drain_ptr];
      rem_mem[wr_ptr] <= rem_vec[drain_ptr];
      dbz_mem[wr_ptr] <= dbz_vec[drain_ptr];
    end
  end

  assign result_valid = (count != '0);
  assign result_count = count;
  assign head_quotient = quo_mem[rd_ptr];
  assign head_remainder = rem_mem[rd_ptr];
  assign head_div_by_zero = dbz_mem[rd_ptr];

  a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    count <= count_w'(result_depth));

endmodule

/* rtl/div_unit_top.sv */
// APB divider with num_lanes parallel lanes; software polls reg_status for results.
`timescale 1ns/1ps

module div_unit_top import div_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [addr_w-1:0] paddr,
  input  logic [data_w-1:0] pwdata,
  output logic [data_w-1:0] prdata,
  output logic              pready,
  output logic              pslverr
);

  logic               cmd_req;
  logic               cmd_signed;
  logic               cmd_accept;
  logic [data_w-1:0]  dividend;
  logic [data_w-1:0]  divisor;
  logic               result_valid;
  logic [data_w-1:0]  head_quotient;
  logic [data_w-1:0]  head_remainder;
  logic               head_div_by_zero;
  logic [count_w-1:0] result_count;
  logic               pop;

  div_lane_if lane_bus [num_lanes] ();

  apb_div_regs i_regs (
    .clk              (clk),
    .rst_n            (rst_n),
    .psel             (psel),
    .penable          (penable),
    .pwrite           (pwrite),
    .paddr            (paddr),
    .pwdata           (pwdata),
    .prdata           (prdata),
    .pready           (pready),
    .pslverr          (pslverr),
    .cmd_req          (cmd_req),
    .cmd_signed       (cmd_signed),
    .cmd_accept       (cmd_accept),
    .dividend         (dividend),
    .divisor          (divisor),
    .result_valid     (result_valid),
    .head_quotient    (head_quotient),
    .head_remainder   (head_remainder),
    .head_div_by_zero (head_div_by_zero),
    .result_count     (result_count),
    .pop              (pop)
  );

  div_dispatch i_dispatch (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_req    (cmd_req),
    .cmd_signed (cmd_signed),
    .dividend   (dividend),
    .divisor    (divisor),
    .cmd_accept (cmd_accept),
    .lanes      (lane_bus)
  );

  for (genvar i = 0; i < num_lanes; i++) begin : g_lane
    div_lane i_lane (
      .clk   (clk),
      .rst_n (rst_n),
      .lane  (lane_bus[i])
    );
  end

  div_collect i_collect (
    .clk              (clk),
    .rst_n            (rst_n),
    .pop              (pop),
    .result_valid     (result_valid),
    .head_quotient    (head_quotient),
    .head_remainder   (head_remainder),
    .head_div_by_zero (head_div_by_zero),
    .result_count     (result_count),
    .lanes            (lane_bus)
  );

endmodule

/* sim/tb_div_unit.sv */
// zero-wait-state APB master; jobs run one at a time except in the back-pressure test.
`timescale 1ns/1ps

module tb_div_unit import div_pkg::*; ();

  // about 40 jobs of roughly 60 cycles each, doubled for margin.
  localparam int max_jobs = 40;
  localparam int cycles_per_job = 60;
  localparam int max_cycles = 2 * max_jobs * cycles_per_job + 200;

  logic              clk;
  logic              rst_n;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [addr_w-1:0] paddr;
  logic [data_w-1:0] pwdata;
  logic [data_w-1:0] prdata;
  logic              pready;
  logic              pslverr;

  int          errors;
  int          checks;
  int          cycles;
  logic [31:0] rng_state;

  div_unit_top i_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------
  function automatic void report_error(input string msg);
    $display("ERROR time=%0t %s", $time, msg);
    errors++;
  endfunction

  task automatic check_value(input string name, input logic [data_w-1:0] got,
                             input logic [data_w-1:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
      errors++;
    end
  endtask

  a_pready_high: assert property (@(posedge clk) disable iff (!rst_n) pready)
    else report_error("pready went low");

  // slave error only on a command write.
  a_pslverr_cmd_only: assert property (@(posedge clk) disable iff (!rst_n)
    pslverr |-> psel && penable && pwrite && (paddr == reg_cmd))
    else report_error("pslverr raised outside a reg_cmd write");

  a_prdata_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
    !(psel && penable && !pwrite) |-> (prdata == '0))
    else report_error("prdata nonzero outside a read access phase");

  // ----------------------------------------
  // stimulus and reference model
  // ----------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // truncate toward zero, remainder follows the dividend.
  task automatic model_div(input logic [data_w-1:0] a, input logic [data_w-1:0] b,
                           input logic sgn, output logic [data_w-1:0] q,
                           output logic [data_w-1:0] r, output logic dbz);
    logic              a_neg;
    logic              b_neg;
    logic [data_w-1:0] ma;
    logic [data_w-1:0] mb;
    a_neg = sgn && a[data_w-1];
    b_neg = sgn && b[data_w-1];
    ma = a_neg ? -a : a;
    mb = b_neg ? -b : b;
    dbz = (b == '0);
    if (dbz) begin
      q = '1;
      r = a;
    end else begin
      q = ma / mb;
      r = ma % mb;
      if (a_neg != b_neg) begin
        q = -q;
      end
      if (a_neg) begin
        r = -r;
      end
    end
  endtask

  // ----------------------------------------
  // APB transfers
  // ----------------------------------------
  // transfers end in the access phase, so they chain back to back.
  task automatic apb_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                           output logic err);
    @(posedge clk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= 1'b1;
    paddr <= addr;
    pwdata <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    err = pslverr;
  endtask

  task automatic apb_read(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data);
    @(posedge clk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= 1'b0;
    paddr <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    data = prdata;
  endtask

  task automatic apb_idle();
    @(posedge clk);
    psel <= 1'b0;
    penable <= 1'b0;
    pwrite <= 1'b0;
  endtask

  task automatic issue_job(input logic [data_w-1:0] a, input logic [data_w-1:0] b,
                           input logic sgn, output logic err);
    logic unused_err;
    apb_write(reg_dividend, a, unused_err);
    apb_write(reg_divisor, b, unused_err);
    apb_write(reg_cmd, data_w'(sgn), err);
  endtask

  task automatic wait_results(input int n);
    logic [data_w-1:0] st;
    st = '0;
    while (int'(st[4:2]) < n) begin
      apb_read(reg_status, st);
      apb_idle();
    end
  endtask

  // the remainder read pops the head entry.
  task automatic read_result(output logic [data_w-1:0] q, output logic [data_w-1:0] st,
                             output logic [data_w-1:0] r);
    apb_read(reg_quotient, q);
    apb_read(reg_status, st);
    apb_read(reg_remainder, r);
    apb_idle();
  endtask

  task automatic check_result(input logic [data_w-1:0] a, input logic [data_w-1:0] b,
                              input logic sgn);
    logic [data_w-1:0] q;
    logic [data_w-1:0] st;
    logic [data_w-1:0] r;
    logic [data_w-1:0] exp_q;
    logic [data_w-1:0] exp_r;
    logic              exp_dbz;
    model_div(a, b, sgn, exp_q, exp_r, exp_dbz);
    read_result(q, st, r);
    check_value("quotient", q, exp_q);
    check_value("remainder", r, exp_r);
    check_value("div_by_zero", data_w'(st[1]), data_w'(exp_dbz));
  endtask

  task automatic run_job(input logic [data_w-1:0] a, input logic [data_w-1:0] b,
                         input logic sgn);
    logic err;
    issue_job(a, b, sgn, err);
    apb_idle();
    check_value("pslverr", data_w'(err), '0);
    wait_results(1);
    check_result(a, b, sgn);
  endtask

  task automatic report_test(input string name, input int first_err);
    $display("test %s: %s", name, (errors == first_err) ? "ok" : "failed");
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    int                first_err;
    logic [data_w-1:0] d;
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    logic [data_w-1:0] t;
    logic [4:0]        sh;
    logic [data_w-1:0] bp_a [5];
    logic [data_w-1:0] bp_b [5];
    logic              bp_err [5];

    errors = 0;
    checks = 0;
    rng_state = 32'd74;
    rst_n <= 1'b0;
    psel <= 1'b0;
    penable <= 1'b0;
    pwrite <= 1'b0;
    paddr <= '0;
    pwdata <= '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    first_err = errors;
    @(negedge clk);
    check_value("pslverr", data_w'(pslverr), '0);
    check_value("prdata", prdata, '0);
    apb_read(reg_status, d);
    apb_idle();
    check_value("reg_status", d, '0);
    apb_read(reg_remainder, d);
    apb_idle();
    check_value("reg_remainder", d, '0);
    apb_read(reg_status, d);
    apb_idle();
    check_value("reg_status", d, '0);
    report_test("after reset", first_err);

    first_err = errors;
    for (int i = 0; i < 16; i++) begin
      a = next_rand();
      sh = 5'(next_rand());
      b = next_rand() >> sh;
      if (b == '0) begin
        b = 32'd1;
      end
      run_job(a, b, 1'b0);
    end
    report_test("unsigned division", first_err);

    // each sign combination twice.
    first_err = errors;
    for (int i = 0; i < 8; i++) begin
      t = next_rand();
      a = {1'b0, t[30:0]};
      sh = 5'(next_rand());
      t = next_rand() >> sh;
      b = {1'b0, t[30:0]} | 32'd1;
      a = i[0] ? -a : a;
      b = i[1] ? -b : b;
      run_job(a, b, 1'b1);
    end
    run_job(32'h8000_0000, 32'hFFFF_FFFF, 1'b1);
    report_test("signed division", first_err);

    first_err = errors;
    run_job(next_rand(), '0, 1'b0);
    run_job(32'h8000_0000 | next_rand(), '0, 1'b1);
    report_test("divide by zero", first_err);

    // five commands well inside one lane latency.
    first_err = errors;
    for (int i = 0; i < 5; i++) begin
      bp_a[i] = next_rand();
      bp_b[i] = (next_rand() >> 8) | 32'd1;
      issue_job(bp_a[i], bp_b[i], i[0], bp_err[i]);
    end
    apb_idle();
    for (int i = 0; i < 4; i++) begin
      check_value("pslverr", data_w'(bp_err[i]), '0);
    end
    check_value("pslverr", data_w'(bp_err[4]), 32'd1);
    wait_results(4);
    for (int i = 0; i < 4; i++) begin
      check_result(bp_a[i], bp_b[i], i[0]);
    end
    apb_read(reg_status, d);
    apb_idle();
    check_value("reg_status", d, '0);
    report_test("back-pressure and ordering", first_err);

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
common/div_pkg.sv
common/div_lane_if.sv
rtl/apb_div_regs.sv
div_array/div_dispatch.sv
div_array/div_lane.sv
div_array/div_collect.sv
rtl/div_unit_top.sv
sim/tb_div_unit.sv

/* run_sim.sh */
#!/bin/sh
# build and run the divider testbench with Verilator, then search the log for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_div_unit -f vlog.f \
  -o tb_div_unit > build.log 2>&1 \
  && ./obj_dir/tb_div_unit > sim.log 2>&1 \
  || { echo "build or simulation run failed"; exit 1; }
grep -qx "TESTS PASSED" sim.log \
  && echo "simulation ok" \
  || { echo "simulation reported failure, see sim.log"; exit 1; }
